// File: hdl/e100_pkg.sv
// shared word, opcode, state and bus-select types for the e100 core, imported by RTL and testbench
package e100_pkg;

    // one machine word, used for memory, registers and the bus
    typedef logic [31:0] word_t;

    // instruction encodings; anything unlisted executes as halt
    typedef enum word_t {
        op_halt = 32'd0,
        op_add  = 32'd1,
        op_sub  = 32'd2,
        op_cp   = 32'd5,
        op_and  = 32'd6,
        op_or   = 32'd7,
        op_not  = 32'd8,
        op_be   = 32'd13,
        op_bne  = 32'd14,
        op_blt  = 32'd15
    } opcode_t;

    // controller states
    typedef enum logic [4:0] {
        st_idle,
        st_fetch1, st_fetch2, st_fetch3, st_fetch4,
        st_fetch5, st_fetch6, st_fetch7, st_fetch8,
        st_decode,
        st_halted,
        st_exec1, st_exec2, st_exec3, st_exec4, st_exec5, st_exec6,
        st_branch_test,
        st_branch_take
    } state_t;

    // source that drives the shared bus
    typedef enum logic [3:0] {
        sel_zero,
        sel_iar,
        sel_plus1,
        sel_arg1,
        sel_arg2,
        sel_arg3,
        sel_memory,
        sel_add,
        sel_sub,
        sel_and,
        sel_or,
        sel_not
    } bus_sel_t;

    // four-phase host port sequencer
    typedef enum logic [1:0] {
        host_idle,
        host_busy,
        host_ack,
        host_drop
    } host_state_t;

    // fixed cycle counts per instruction
    localparam int fetch_cycles       = 9;
    localparam int alu_exec_cycles    = 6;
    localparam int move_exec_cycles   = 4;
    localparam int branch_exec_cycles = 5;
    localparam int branch_take_cycles = 6;
    localparam int halt_cycles        = 1;

endpackage

// File: hdl/e100_control.sv
// e100 controller FSM: walks fetch, decode and execute and drives the datapath and memory strobes
`timescale 1ns/1ps

module e100_control import e100_pkg::*; (
    input  logic     clock,
    input  logic     reset,
    input  logic     run,
    input  opcode_t  opcode,
    input  logic     equal,
    input  logic     less_than,
    output logic     iar_write,
    output logic     op1_write,
    output logic     op2_write,
    output logic     opcode_write,
    output logic     arg1_write,
    output logic     arg2_write,
    output logic     arg3_write,
    output bus_sel_t bus_sel,
    output logic     address_write,
    output logic     memory_write,
    output logic     running,
    output logic     halted
);

    state_t state;
    state_t next_state;
    logic   branch_taken;
    logic   is_branch;
    logic   short_op;

    always_comb begin
        case (opcode)
            op_be:   branch_taken = equal;
            op_bne:  branch_taken = !equal;
            op_blt:  branch_taken = less_than;
            default: branch_taken = 1'b0;
        endcase
    end

    assign is_branch = (opcode == op_be) || (opcode == op_bne) || (opcode == op_blt);
    // not and cp skip the second operand load
    assign short_op = (opcode == op_not) || (opcode == op_cp);

    always_comb begin
        iar_write     = 1'b0;
        op1_write     = 1'b0;
        op2_write     = 1'b0;
        opcode_write  = 1'b0;
        arg1_write    = 1'b0;
        arg2_write    = 1'b0;
        arg3_write    = 1'b0;
        address_write = 1'b0;
        memory_write  = 1'b0;
        bus_sel       = sel_zero;
        next_state    = state;

        if (!run && state != st_idle) begin
            // run dropped, park the program counter at zero
            iar_write  = 1'b1;
            next_state = st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (run) begin
                        next_state = st_fetch1;
                    end
                end
                st_fetch1: begin
                    bus_sel       = sel_iar;
                    address_write = 1'b1;
                    next_state    = st_fetch2;
                end
                st_fetch2: begin
                    bus_sel      = sel_memory;
                    opcode_write = 1'b1;
                    next_state   = st_fetch3;
                end
                st_fetch3, st_fetch5, st_fetch7: begin
                    // step to the next instruction word
                    bus_sel       = sel_plus1;
                    iar_write     = 1'b1;
                    address_write = 1'b1;
                    next_state    = state_t'(state + 1'b1);
                end
                st_fetch4: begin
                    bus_sel    = sel_memory;
                    arg1_write = 1'b1;
                    next_state = st_fetch5;
                end
                st_fetch6: begin
                    bus_sel    = sel_memory;
                    arg2_write = 1'b1;
                    next_state = st_fetch7;
                end
                st_fetch8: begin
                    bus_sel    = sel_memory;
                    arg3_write = 1'b1;
                    next_state = st_decode;
                end
                st_decode: begin
                    // pc past the four-word instruction
                    bus_sel    = sel_plus1;
                    iar_write  = 1'b1;
                    next_state = (opcode == op_halt) ? st_halted : st_exec1;
                end
                st_halted: begin
                    next_state = st_halted;
                end
                st_exec1: begin
                    bus_sel       = sel_arg2;
                    address_write = 1'b1;
                    next_state    = st_exec2;
                end
                st_exec2: begin
                    // cp parks mem[arg2] in arg3
                    bus_sel    = sel_memory;
                    op1_write  = (opcode != op_cp);
                    arg3_write = (opcode == op_cp);
                    next_state = short_op ? st_exec5 : st_exec3;
                end
                st_exec3: begin
                    bus_sel       = sel_arg3;
                    address_write = 1'b1;
                    next_state    = st_exec4;
                end
                st_exec4: begin
                    bus_sel    = sel_memory;
                    op2_write  = 1'b1;
                    next_state = is_branch ? st_branch_test : st_exec5;
                end
                st_exec5: begin
                    bus_sel       = sel_arg1;
                    address_write = 1'b1;
                    next_state    = st_exec6;
                end
                st_exec6: begin
                    case (opcode)
                        op_add:  bus_sel = sel_add;
                        op_sub:  bus_sel = sel_sub;
                        op_and:  bus_sel = sel_and;
                        op_or:   bus_sel = sel_or;
                        op_not:  bus_sel = sel_not;
                        default: bus_sel = sel_arg3;
                    endcase
                    memory_write = 1'b1;
                    next_state   = st_fetch1;
                end
                st_branch_test: begin
                    next_state = branch_taken ? st_branch_take : st_fetch1;
                end
                st_branch_take: begin
                    bus_sel    = sel_arg1;
                    iar_write  = 1'b1;
                    next_state = st_fetch1;
                end
                default: begin
                    next_state = st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= st_idle;
        end else begin
            state <= next_state;
        end
    end

    assign running = (state != st_idle) && (state != st_halted);
    // halted only while the host still holds run
    assign halted = (state == st_halted) && run;

endmodule

// File: hdl/e100_datapath.sv
// e100 datapath: program counter, operand and instruction registers, bus mux, logic unit and compare
`timescale 1ns/1ps

module e100_datapath import e100_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic     clock,
    input  logic     reset,
    input  logic     iar_write,
    input  logic     op1_write,
    input  logic     op2_write,
    input  logic     opcode_write,
    input  logic     arg1_write,
    input  logic     arg2_write,
    input  logic     arg3_write,
    input  bus_sel_t bus_sel,
    input  word_t    mem_data,
    output word_t    bus,
    output opcode_t  opcode,
    output logic     equal,
    output logic     less_than
);

    // pc only spans the memory, so it wraps at the top address
    logic [ADDR_WIDTH-1:0] iar;
    logic [ADDR_WIDTH-1:0] iar_plus1;
    word_t                 op1;
    word_t                 op2;
    word_t                 opcode_reg;
    word_t                 arg1;
    word_t                 arg2;
    word_t                 arg3;

    assign iar_plus1 = iar + 1'b1;

    always_ff @(posedge clock) begin
        if (reset) begin
            iar <= '0;
        end else if (iar_write) begin
            iar <= bus[ADDR_WIDTH-1:0];
        end
    end

    always_ff @(posedge clock) begin
        if (op1_write) begin
            op1 <= bus;
        end
        if (op2_write) begin
            op2 <= bus;
        end
        if (opcode_write) begin
            opcode_reg <= bus;
        end
        if (arg1_write) begin
            arg1 <= bus;
        end
        if (arg2_write) begin
            arg2 <= bus;
        end
        if (arg3_write) begin
            arg3 <= bus;
        end
    end

    always_comb begin
        case (bus_sel)
            sel_iar:    bus = word_t'(iar);
            sel_plus1:  bus = word_t'(iar_plus1);
            sel_arg1:   bus = arg1;
            sel_arg2:   bus = arg2;
            sel_arg3:   bus = arg3;
            sel_memory: bus = mem_data;
            sel_add:    bus = op1 + op2;
            sel_sub:    bus = op1 - op2;
            sel_and:    bus = op1 & op2;
            sel_or:     bus = op1 | op2;
            sel_not:    bus = ~op1;
            default:    bus = '0;
        endcase
    end

    // unknown encodings fall back to halt
    always_comb begin
        case (opcode_reg)
            op_add, op_sub, op_cp, op_and, op_or, op_not, op_be, op_bne, op_blt: begin
                opcode = opcode_t'(opcode_reg);
            end
            default: begin
                opcode = op_halt;
            end
        endcase
    end

    assign equal     = (op1 == op2);
    assign less_than = (op1 < op2);

endmodule

// File: hdl/e100_memory.sv
// e100 word memory with its address register and a four-phase req/ack host port for load and dump
`timescale 1ns/1ps

module e100_memory import e100_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  address_write,
    input  logic                  memory_write,
    input  word_t                 bus,
    output word_t                 mem_data,
    input  logic                  running,
    input  logic                  req,
    input  logic                  write,
    input  logic [ADDR_WIDTH-1:0] host_addr,
    input  word_t                 wdata,
    output logic                  ack,
    output word_t                 rdata
);

    localparam int depth = 2 ** ADDR_WIDTH;

    word_t                 mem [depth];
    logic [ADDR_WIDTH-1:0] address;
    host_state_t           host_state;
    logic                  host_start;

    // host requests wait here while a program runs
    assign host_start = (host_state == host_idle) && req && !running;

    assign mem_data = mem[address];
    assign ack      = (host_state == host_ack) || (host_state == host_drop);

    always_ff @(posedge clock) begin
        if (address_write) begin
            address <= bus[ADDR_WIDTH-1:0];
        end
    end

    // single write port, core first
    always_ff @(posedge clock) begin
        if (memory_write) begin
            mem[address] <= bus;
        end else if (host_start && write) begin
            mem[host_addr] <= wdata;
        end
    end

    always_ff @(posedge clock) begin
        if (host_state == host_busy) begin
            rdata <= mem[host_addr];
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            host_state <= host_idle;
        end else begin
            case (host_state)
                host_idle: host_state <= host_start ? host_busy : host_idle;
                host_busy: host_state <= host_ack;
                host_ack:  host_state <= req ? host_ack : host_drop;
                default:   host_state <= host_idle;
            endcase
        end
    end

endmodule

// File: hdl/e100_core.sv
// e100 core top level: ties controller, datapath and memory together and sets the address width
`timescale 1ns/1ps

module e100_core import e100_pkg::*; #(
    parameter int ADDR_WIDTH = 8
) (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  run,
    input  logic                  req,
    input  logic                  write,
    input  logic [ADDR_WIDTH-1:0] host_addr,
    input  word_t                 wdata,
    output logic                  ack,
    output word_t                 rdata,
    output logic                  running,
    output logic                  halted
);

    logic     iar_write;
    logic     op1_write;
    logic     op2_write;
    logic     opcode_write;
    logic     arg1_write;
    logic     arg2_write;
    logic     arg3_write;
    bus_sel_t bus_sel;
    logic     address_write;
    logic     memory_write;
    word_t    bus;
    word_t    mem_data;
    opcode_t  opcode;
    logic     equal;
    logic     less_than;

    e100_control control (
        .clock(clock), .reset(reset), .run(run),
        .opcode(opcode), .equal(equal), .less_than(less_than),
        .iar_write(iar_write), .op1_write(op1_write), .op2_write(op2_write),
        .opcode_write(opcode_write), .arg1_write(arg1_write),
        .arg2_write(arg2_write), .arg3_write(arg3_write), .bus_sel(bus_sel),
        .address_write(address_write), .memory_write(memory_write),
        .running(running), .halted(halted)
    );

    e100_datapath #(.ADDR_WIDTH(ADDR_WIDTH)) datapath (
        .clock(clock), .reset(reset),
        .iar_write(iar_write), .op1_write(op1_write), .op2_write(op2_write),
        .opcode_write(opcode_write), .arg1_write(arg1_write),
        .arg2_write(arg2_write), .arg3_write(arg3_write), .bus_sel(bus_sel),
        .mem_data(mem_data), .bus(bus), .opcode(opcode),
        .equal(equal), .less_than(less_than)
    );

    e100_memory #(.ADDR_WIDTH(ADDR_WIDTH)) memory (
        .clock(clock), .reset(reset),
        .address_write(address_write), .memory_write(memory_write),
        .bus(bus), .mem_data(mem_data), .running(running),
        .req(req), .write(write), .host_addr(host_addr), .wdata(wdata),
        .ack(ack), .rdata(rdata)
    );

endmodule

// File: verification/e100_checker.sv
// e100 checker: watches the host port and run control of the core and compares against expected values
`timescale 1ns/1ps

module e100_checker import e100_pkg::*; (
    input logic  clock,
    input logic  reset,
    input logic  run,
    input logic  running,
    input logic  halted,
    input logic  write,
    input logic  ack,
    input word_t rdata
);

    string current_name = "none";
    word_t expected_value = '0;
    int    expected_run_cycles = 0;
    int    run_cycles = 0;
    int    check_count = 0;
    int    error_count = 0;
    logic  ack_seen;
    logic  halted_seen;

    // next host read is compared against this value
    task automatic expect_read(input string name, input word_t value);
        current_name   = name;
        expected_value = value;
    endtask

    // cycles from the first edge that samples run high until halted
    task automatic expect_cycles(input string name, input int cycles);
        current_name        = name;
        expected_run_cycles = cycles;
    endtask

    task automatic report_counts(input int timeouts);
        $display("checks: %0d, errors: %0d, timeouts: %0d", check_count, error_count, timeouts);
    endtask

    always @(posedge clock) begin
        if (reset) begin
            run_cycles  <= 0;
            ack_seen    <= 1'b0;
            halted_seen <= 1'b0;
        end else begin
            ack_seen    <= ack;
            halted_seen <= halted;
            if (!run) begin
                run_cycles <= 0;
            end else if (!halted) begin
                run_cycles <= run_cycles + 1;
            end
            // host accesses must wait for the program to finish
            if (ack && running) begin
                $display("error: host port acknowledged an access while the core was running");
                error_count = error_count + 1;
            end
            if (ack && !ack_seen && !write) begin
                check_count = check_count + 1;
                if (rdata !== expected_value) begin
                    $display("[ERROR] %s: expected 0x%08h, actual 0x%08h",
                             current_name, expected_value, rdata);
                    error_count = error_count + 1;
                end else begin
                    $display("ok %s: 0x%08h", current_name, rdata);
                end
            end
            if (halted && !halted_seen) begin
                check_count = check_count + 1;
                if (run_cycles != expected_run_cycles) begin
                    $display("[ERROR] %s run cycles: expected %0d, actual %0d",
                             current_name, expected_run_cycles, run_cycles);
                    error_count = error_count + 1;
                end
            end
        end
    end

endmodule

// File: verification/e100_sva.sv
// e100 run-control and host handshake assertions, bound into every e100_core instance
`timescale 1ns/1ps

module e100_sva (
    input logic clock,
    input logic reset,
    input logic run,
    input logic req,
    input logic ack,
    input logic running,
    input logic halted
);

    int failure_count = 0;

    // ack is registered, so req is checked one edge back
    ack_needs_req: assert property (@(posedge clock) disable iff (reset) $rose(ack) |-> $past(req))
        else begin
            $error("ack rose without a host request");
            failure_count++;
        end

    run_state_exclusive: assert property (@(posedge clock) disable iff (reset)
        !(running && halted))
        else begin
            $error("running and halted are high together");
            failure_count++;
        end

    halted_needs_run: assert property (@(posedge clock) disable iff (reset) halted |-> run)
        else begin
            $error("halted is high while run is low");
            failure_count++;
        end

    // two quiet cycles on the host port once reset is released
    ack_quiet_after_reset: assert property (@(posedge clock) (reset || $past(reset)) |=> !ack)
        else begin
            $error("ack is high right after reset");
            failure_count++;
        end

endmodule

bind e100_core e100_sva assertions (
    .clock(clock), .reset(reset), .run(run), .req(req), .ack(ack),
    .running(running), .halted(halted)
);

// File: verification/e100_tb.sv
// e100 testbench top: clock, reset, test table, program loader and run loop around e100_core
`timescale 1ns/1ps

module e100_tb import e100_pkg::*; ();

    localparam int addr_width   = 8;
    localparam int num_tests    = 14;
    localparam int start_cycles = 1;
    localparam int ack_timeout  = 200;
    localparam int run_timeout  = 3 * fetch_cycles + 2 * branch_take_cycles + 8;

    typedef logic [addr_width-1:0] addr_t;

    // data words the test programs use
    localparam addr_t result_addr = addr_t'(40);
    localparam addr_t a_addr      = addr_t'(41);
    localparam addr_t b_addr      = addr_t'(42);
    localparam addr_t one_addr    = addr_t'(43);
    localparam addr_t marker_addr = addr_t'(44);

    logic  clock;
    logic  reset;
    logic  run;
    logic  req;
    logic  write;
    addr_t host_addr;
    word_t wdata;
    logic  ack;
    word_t rdata;
    logic  running;
    logic  halted;

    string   test_name   [num_tests];
    opcode_t test_op     [num_tests];
    word_t   test_a      [num_tests];
    word_t   test_b      [num_tests];
    word_t   test_exp    [num_tests];
    int      test_cycles [num_tests];
    word_t   lcg_state;
    int      timeouts;

    e100_core #(.ADDR_WIDTH(addr_width)) UUT (
        .clock(clock), .reset(reset), .run(run),
        .req(req), .write(write), .host_addr(host_addr), .wdata(wdata),
        .ack(ack), .rdata(rdata), .running(running), .halted(halted)
    );

    e100_checker check_unit (
        .clock(clock), .reset(reset), .run(run), .running(running), .halted(halted),
        .write(write), .ack(ack), .rdata(rdata)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #20 clock = ~clock;
        end
    end

    function word_t lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic is_branch(opcode_t op);
        return (op == op_be) || (op == op_bne) || (op == op_blt);
    endfunction

    // branch rows store 1 in the result exactly when the branch is taken
    function automatic word_t expected_word(opcode_t op, word_t a, word_t b);
        case (op)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_not:  return ~a;
            op_cp:   return a;
            op_be:   return (a == b) ? 32'd1 : 32'd0;
            op_bne:  return (a != b) ? 32'd1 : 32'd0;
            op_blt:  return (a < b) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    function automatic int expected_cycles(opcode_t op, word_t a, word_t b);
        int exec;
        exec = alu_exec_cycles;
        if (op == op_not || op == op_cp) begin
            exec = move_exec_cycles;
        end
        if (is_branch(op)) begin
            // taken path also runs the cp at address 8
            if (expected_word(op, a, b) == 32'd1) begin
                exec = branch_take_cycles + fetch_cycles + move_exec_cycles;
            end else begin
                exec = branch_exec_cycles;
            end
        end
        return start_cycles + fetch_cycles + exec + fetch_cycles;
    endfunction

    task automatic add_row(input int idx, input string name, input opcode_t op,
                           input word_t a, input word_t b);
        test_name[idx]   = name;
        test_op[idx]     = op;
        test_a[idx]      = a;
        test_b[idx]      = b;
        test_exp[idx]    = expected_word(op, a, b);
        test_cycles[idx] = expected_cycles(op, a, b);
    endtask

    task automatic build_table();
        add_row(0, "add", op_add, lcg_next(), lcg_next());
        add_row(1, "sub", op_sub, lcg_next(), lcg_next());
        add_row(2, "and", op_and, lcg_next(), lcg_next());
        add_row(3, "or", op_or, lcg_next(), lcg_next());
        add_row(4, "not", op_not, lcg_next(), 32'd0);
        add_row(5, "cp", op_cp, lcg_next(), 32'd0);
        add_row(6, "be_equal", op_be, 32'h0000_1234, 32'h0000_1234);
        add_row(7, "be_unequal", op_be, 32'd5, 32'd9);
        add_row(8, "bne_equal", op_bne, 32'd7, 32'd7);
        add_row(9, "bne_unequal", op_bne, 32'd3, 32'd8);
        add_row(10, "blt_lower", op_blt, 32'd2, 32'h8000_0000);
        add_row(11, "blt_higher", op_blt, 32'hffff_fff0, 32'd4);
        add_row(12, "blt_equal", op_blt, 32'd6, 32'd6);
        add_row(13, "add_wrap", op_add, 32'hffff_ffff, 32'd2);
    endtask

    task automatic next_cycle();
        @(posedge clock);
        #2;
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        timeouts++;
    endtask

    // one four-phase transfer on the host port
    task automatic host_access(input logic wr, input addr_t addr, input word_t data);
        int waited;
        waited    = 0;
        req       = 1'b1;
        write     = wr;
        host_addr = addr;
        wdata     = data;
        while (!ack && waited < ack_timeout) begin
            next_cycle();
            waited++;
        end
        req = 1'b0;
        if (!ack) begin
            report_timeout("host port never acknowledged the request");
            return;
        end
        waited = 0;
        while (ack && waited < ack_timeout) begin
            next_cycle();
            waited++;
        end
        if (ack) begin
            report_timeout("host port kept ack high after req dropped");
        end
    endtask

    // the core must sample run low at least once to return to idle
    task automatic stop_run();
        int waited;
        waited = 0;
        run    = 1'b0;
        next_cycle();
        while (running && waited < run_timeout) begin
            next_cycle();
            waited++;
        end
        if (running) begin
            report_timeout("core kept running after run dropped");
        end
    endtask

    task automatic start_run();
        int waited;
        waited = 0;
        run    = 1'b1;
        while (!running && waited < run_timeout) begin
            next_cycle();
            waited++;
        end
        if (!running) begin
            report_timeout("core did not start running");
        end
    endtask

    task automatic wait_halted();
        int waited;
        waited = 0;
        while (!halted && waited < run_timeout) begin
            next_cycle();
            waited++;
        end
        if (!halted) begin
            report_timeout("core did not reach the halted state");
        end
    endtask

    // instruction at 0, halt at 4, cp 40,43 at 8, halt at 12, then the data words
    task automatic load_program(input opcode_t op, input word_t a, input word_t b);
        word_t image [16];
        for (int k = 0; k < 16; k++) begin
            image[k] = 32'hfee0_0000 | word_t'(k);
        end
        image[0]  = word_t'(op);
        image[1]  = is_branch(op) ? 32'd8 : word_t'(result_addr);
        image[2]  = word_t'(a_addr);
        image[3]  = word_t'(b_addr);
        image[4]  = word_t'(op_halt);
        image[8]  = word_t'(op_cp);
        image[9]  = word_t'(result_addr);
        image[10] = word_t'(one_addr);
        image[12] = word_t'(op_halt);
        for (int k = 0; k < 16; k++) begin
            host_access(1'b1, addr_t'(k), image[k]);
            if (timeouts != 0) return;
        end
        host_access(1'b1, a_addr, a);
        host_access(1'b1, b_addr, b);
        host_access(1'b1, result_addr, 32'd0);
        host_access(1'b1, one_addr, 32'd1);
    endtask

    task automatic run_row(input int idx);
        stop_run();
        if (timeouts != 0) return;
        load_program(test_op[idx], test_a[idx], test_b[idx]);
        if (timeouts != 0) return;
        check_unit.expect_cycles(test_name[idx], test_cycles[idx]);
        start_run();
        if (timeouts != 0) return;
        wait_halted();
        if (timeouts != 0) return;
        check_unit.expect_read(test_name[idx], test_exp[idx]);
        host_access(1'b0, result_addr, 32'd0);
    endtask

    // host write, then host read, each raised while a program is running
    task automatic held_access_test();
        word_t a;
        word_t b;
        word_t marker;
        a      = lcg_next();
        b      = lcg_next();
        marker = lcg_next();
        stop_run();
        if (timeouts != 0) return;
        load_program(op_add, a, b);
        if (timeouts != 0) return;
        check_unit.expect_cycles("held_write", expected_cycles(op_add, a, b));
        start_run();
        if (timeouts != 0) return;
        host_access(1'b1, marker_addr, marker);
        if (timeouts != 0) return;
        stop_run();
        if (timeouts != 0) return;
        check_unit.expect_cycles("held_read", expected_cycles(op_add, a, b));
        start_run();
        if (timeouts != 0) return;
        check_unit.expect_read("held_read", expected_word(op_add, a, b));
        host_access(1'b0, result_addr, 32'd0);
        if (timeouts != 0) return;
        check_unit.expect_read("held_write", marker);
        host_access(1'b0, marker_addr, 32'd0);
    endtask

    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        req       = 1'b0;
        write     = 1'b0;
        host_addr = '0;
        wdata     = '0;
        timeouts  = 0;
        lcg_state = 32'd33935;
        build_table();
        repeat (2) @(posedge clock);
        #2;
        reset = 1'b0;
        for (int i = 0; i < num_tests && timeouts == 0; i++) begin
            run_row(i);
        end
        if (timeouts == 0) begin
            held_access_test();
        end
        check_unit.report_counts(timeouts);
        if (timeouts == 0 && check_unit.error_count == 0 &&
            UUT.assertions.failure_count == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
hdl/e100_pkg.sv
hdl/e100_control.sv
hdl/e100_datapath.sv
hdl/e100_memory.sv
hdl/e100_core.sv
verification/e100_checker.sv
verification/e100_sva.sv
verification/e100_tb.sv

// File: Makefile
VERILATOR    ?= verilator
VFLAGS       ?= --binary --timing --assert --timescale 1ns/1ps
TOP          ?= e100_tb
FILELIST     ?= vlog.f
OBJ_DIR      := obj_dir
SIM          := $(OBJ_DIR)/V$(TOP)
LOG          := sim.log
PASS_PATTERN := TEST RESULT: PASS
SOURCES      := $(filter-out +%,$(shell cat $(FILELIST)))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_PATTERN)" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
